// File: files.f
+incdir+verification
verilog/mem_pkg.sv
verilog/rdma_pkg.sv
verilog/qp_context_table.sv
verilog/req_dispatch.sv
verilog/ack_queue.sv
verilog/roce_stack.sv
verification/tb_roce_stack.sv

// File: run_sim.sh
#!/bin/sh
# Build and run the RoCE command-path testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing -sv -Wno-fatal -f files.f --top-module tb_roce_stack

out=$(./obj_dir/Vtb_roce_stack)
echo "$out"

if echo "$out" | grep -q "^Result: PASSED$"; then
  exit 0
else
  exit 1
fi

// File: verification/tb_roce_ref.svh
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// RoCE command path reference model
// Expected command and ACK for one request, and the value compare
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`ifndef TB_ROCE_REF_SVH
`define TB_ROCE_REF_SVH

typedef struct packed {
  logic            has_cmd;
  logic            cmd_is_rd;
  logic            is_drop;
  mem_pkg::vaddr_t vaddr;
  mem_pkg::len_t   len;
  logic            stream;
  logic            host;
  mem_pkg::pid_t   pid;
  mem_pkg::vfid_t  vfid;
  logic            is_nak;
} exp_item_t;

// Outcome of one request against the QP entry it names
function automatic exp_item_t predict_request(
  input rdma_pkg::rdma_opcode_t opcode,
  input logic                   host,
  input logic                   mode,
  input mem_pkg::vaddr_t        vaddr,
  input mem_pkg::len_t          len,
  input logic                   qp_en,
  input mem_pkg::pid_t          qp_pid,
  input mem_pkg::vfid_t         qp_vfid
);
  exp_item_t item;
  logic      op_write;
  logic      op_read;
  op_write       = (opcode == rdma_pkg::OP_RDMA_WRITE);
  op_read        = (opcode == rdma_pkg::OP_RDMA_READ);
  item.has_cmd   = qp_en && (op_write || op_read);
  // A WRITE fetches local data, so it goes out as a memory read
  item.cmd_is_rd = op_write;
  item.is_drop   = !qp_en;
  item.is_nak    = !item.has_cmd;
  item.vaddr     = vaddr;
  item.len       = len;
  item.stream    = mode;
  item.host      = host;
  item.pid       = qp_pid;
  item.vfid      = qp_vfid;
  return item;
endfunction

task automatic check_value(input string name, input logic [63:0] got, input logic [63:0] exp);
  if (got !== exp) begin
    value_errors++;
    $display("FAILED %s: got 0x%0h, expected 0x%0h", name, got, exp);
  end
endtask

`endif

// File: verification/tb_roce_stack.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Testbench for the RoCE command path
// Directed and random requests, checked against a reference model
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ps

module tb_roce_stack;

  import rdma_pkg::*;
  import mem_pkg::*;

  localparam int CLK_HALF     = 10;
  localparam int RESET_CYCLES = 5;
  localparam int N_RANDOM     = 200;
  // About 5 cycles per random request at 75% ready
  // and a short directed part, so 4000 leaves ample margin
  localparam int TIMEOUT_CYCLES = 4000;

  logic         nclk;
  logic         nresetn;
  logic         sq_valid;
  logic         sq_ready;
  rdma_opcode_t sq_opcode;
  qpn_t         sq_qpn;
  logic         sq_host;
  logic         sq_mode;
  vaddr_t       sq_vaddr;
  len_t         sq_len;
  logic         rd_req_valid;
  logic         rd_req_ready;
  vaddr_t       rd_req_vaddr;
  len_t         rd_req_len;
  logic         rd_req_stream;
  logic         rd_req_host;
  pid_t         rd_req_pid;
  vfid_t        rd_req_vfid;
  logic         wr_req_valid;
  logic         wr_req_ready;
  vaddr_t       wr_req_vaddr;
  len_t         wr_req_len;
  logic         wr_req_stream;
  logic         wr_req_host;
  pid_t         wr_req_pid;
  vfid_t        wr_req_vfid;
  logic         ack_valid;
  logic         ack_ready;
  logic         ack_is_nak;
  pid_t         ack_pid;
  vfid_t        ack_vfid;
  logic         qp_wr;
  qpn_t         qp_qpn;
  logic         qp_enable;
  pid_t         qp_pid;
  vfid_t        qp_vfid;
  logic         invalid_qp_drop_count_valid;
  drop_count_t  invalid_qp_drop_count_data;

  int   value_errors;
  int   other_errors;
  int   cycle_count;
  int   sq_count;
  int   exp_drops;
  int   drops_seen;
  int   base;
  logic ready_random;
  logic ack_hold;

  `include "tb_roce_ref.svh"

  // Shadow of the QP context table
  logic      shadow_en   [N_QP];
  pid_t      shadow_pid  [N_QP];
  vfid_t     shadow_vfid [N_QP];
  exp_item_t exp_cmd_q [$];
  exp_item_t exp_ack_q [$];
  exp_item_t mon_item;

  roce_stack UUT (.*);

  initial begin
    nclk = 1'b0;
    forever #CLK_HALF nclk = ~nclk;
  end

  always @(posedge nclk) begin
    cycle_count++;
    if (cycle_count >= TIMEOUT_CYCLES) begin
      $display("Timeout after %0d cycles, requests stopped completing", cycle_count);
      $display("Result: FAILED");
      $finish;
    end
  end

  // Ready on all outputs, random or held
  always @(posedge nclk) begin
    #2;
    if (ready_random) begin
      rd_req_ready = ($urandom_range(0, 3) != 0);
      wr_req_ready = ($urandom_range(0, 3) != 0);
      ack_ready    = ($urandom_range(0, 3) != 0);
    end else begin
      rd_req_ready = 1'b1;
      wr_req_ready = 1'b1;
      ack_ready    = !ack_hold;
    end
  end

  task automatic check_cmd(input logic is_rd, input vaddr_t vaddr, input len_t len,
                           input logic stream, input logic host, input pid_t pid,
                           input vfid_t vfid);
    exp_item_t exp;
    string     pfx;
    pfx = is_rd ? "rd_req" : "wr_req";
    if (exp_cmd_q.size() == 0) begin
      other_errors++;
      $display("Unexpected command on %s while no request expects one", pfx);
    end else begin
      exp = exp_cmd_q.pop_front();
      if (exp.cmd_is_rd != is_rd) begin
        other_errors++;
        $display("Command came out on %s, but the request needs the other port", pfx);
      end
      check_value({pfx, "_vaddr"}, vaddr, exp.vaddr);
      check_value({pfx, "_len"}, len, exp.len);
      check_value({pfx, "_stream"}, stream, exp.stream);
      check_value({pfx, "_host"}, host, exp.host);
      check_value({pfx, "_pid"}, pid, exp.pid);
      check_value({pfx, "_vfid"}, vfid, exp.vfid);
    end
  endtask

  task automatic check_ack();
    exp_item_t exp;
    if (exp_ack_q.size() == 0) begin
      other_errors++;
      $display("Unexpected ACK while no request is outstanding");
    end else begin
      exp = exp_ack_q.pop_front();
      check_value("ack_is_nak", ack_is_nak, exp.is_nak);
      check_value("ack_pid", ack_pid, exp.pid);
      check_value("ack_vfid", ack_vfid, exp.vfid);
    end
  endtask

  // Sampled mid-cycle, where every handshake signal is settled
  always @(negedge nclk) begin
    if (nresetn) begin
      if (sq_valid && sq_ready) begin
        mon_item = predict_request(sq_opcode, sq_host, sq_mode, sq_vaddr, sq_len,
                                   shadow_en[sq_qpn], shadow_pid[sq_qpn], shadow_vfid[sq_qpn]);
        if (mon_item.has_cmd) begin
          exp_cmd_q.push_back(mon_item);
        end
        exp_ack_q.push_back(mon_item);
        if (mon_item.is_drop) begin
          exp_drops++;
        end
        sq_count++;
      end
      if (rd_req_valid && rd_req_ready) begin
        check_cmd(1'b1, rd_req_vaddr, rd_req_len, rd_req_stream, rd_req_host,
                  rd_req_pid, rd_req_vfid);
      end
      if (wr_req_valid && wr_req_ready) begin
        check_cmd(1'b0, wr_req_vaddr, wr_req_len, wr_req_stream, wr_req_host,
                  wr_req_pid, wr_req_vfid);
      end
      if (ack_valid && ack_ready) begin
        check_ack();
      end
      // The pulse follows the lookup of the last accepted request
      if (invalid_qp_drop_count_valid) begin
        drops_seen++;
        check_value("invalid_qp_drop_count_data", invalid_qp_drop_count_data, exp_drops);
      end
    end
  end

  // Called and returning 2 ns after a rising edge
  task automatic write_qp(input qpn_t qpn, input logic en, input pid_t pid, input vfid_t vfid);
    qp_wr     = 1'b1;
    qp_qpn    = qpn;
    qp_enable = en;
    qp_pid    = pid;
    qp_vfid   = vfid;
    @(posedge nclk);
    #2;
    qp_wr             = 1'b0;
    shadow_en[qpn]    = en;
    shadow_pid[qpn]   = pid;
    shadow_vfid[qpn]  = vfid;
  endtask

  task automatic send_req(input rdma_opcode_t op, input qpn_t qpn, input logic host,
                          input logic mode, input vaddr_t vaddr, input len_t len);
    logic taken;
    sq_valid  = 1'b1;
    sq_opcode = op;
    sq_qpn    = qpn;
    sq_host   = host;
    sq_mode   = mode;
    sq_vaddr  = vaddr;
    sq_len    = len;
    taken     = 1'b0;
    while (!taken) begin
      @(negedge nclk);
      taken = sq_ready;
      @(posedge nclk);
      #2;
    end
    sq_valid = 1'b0;
  endtask

  task automatic send_random_req();
    rdma_opcode_t op;
    int           pick;
    pick = $urandom_range(0, 9);
    if (pick < 4) begin
      op = OP_RDMA_WRITE;
    end else if (pick < 8) begin
      op = OP_RDMA_READ;
    end else begin
      op = rdma_opcode_t'($urandom_range(0, 31));
    end
    send_req(op, qpn_t'($urandom_range(0, N_QP - 1)), ($urandom_range(0, 1) != 0),
             ($urandom_range(0, 1) != 0), vaddr_t'({$urandom, $urandom}), len_t'($urandom));
  endtask

  // Until total requests are accepted and every ACK is back
  task automatic wait_drain(input int total);
    do begin
      @(posedge nclk);
    end while (sq_count < total || exp_ack_q.size() != 0);
    #2;
  endtask

  initial begin
    void'($urandom(32'h7373));
    nresetn      = 1'b0;
    sq_valid     = 1'b0;
    sq_opcode    = '0;
    sq_qpn       = '0;
    sq_host      = 1'b0;
    sq_mode      = 1'b0;
    sq_vaddr     = '0;
    sq_len       = '0;
    rd_req_ready = 1'b1;
    wr_req_ready = 1'b1;
    ack_ready    = 1'b1;
    qp_wr        = 1'b0;
    qp_qpn       = '0;
    qp_enable    = 1'b0;
    qp_pid       = '0;
    qp_vfid      = '0;
    ready_random = 1'b0;
    ack_hold     = 1'b0;
    value_errors = 0;
    other_errors = 0;
    cycle_count  = 0;
    sq_count     = 0;
    exp_drops    = 0;
    drops_seen   = 0;
    for (int q = 0; q < N_QP; q++) begin
      shadow_en[q]   = 1'b0;
      shadow_pid[q]  = '0;
      shadow_vfid[q] = '0;
    end

    repeat (RESET_CYCLES - 1) @(posedge nclk);
    @(negedge nclk);
    check_value("sq_ready", sq_ready, 1'b0);
    check_value("rd_req_valid", rd_req_valid, 1'b0);
    check_value("wr_req_valid", wr_req_valid, 1'b0);
    check_value("ack_valid", ack_valid, 1'b0);
    check_value("invalid_qp_drop_count_valid", invalid_qp_drop_count_valid, 1'b0);
    @(posedge nclk);
    #2;
    nresetn = 1'b1;

    // WRITE and READ on an enabled QP
    write_qp(4'd3, 1'b1, 6'h2a, 1'b1);
    send_req(OP_RDMA_WRITE, 4'd3, 1'b1, 1'b0, 48'h1234_5678_9abc, 28'h000_0400);
    wait_drain(sq_count);
    send_req(OP_RDMA_READ, 4'd3, 1'b0, 1'b1, 48'h0000_cafe_0000, 28'h123_4567);
    wait_drain(sq_count);

    // Disabled QP counts a drop, an unknown opcode does not
    send_req(OP_RDMA_WRITE, 4'd9, 1'b0, 1'b0, 48'h0000_0000_1000, 28'h000_0040);
    wait_drain(sq_count);
    check_value("invalid_qp_drop_count_data", invalid_qp_drop_count_data, 1);
    send_req(5'h04, 4'd3, 1'b0, 1'b0, 48'h0000_0000_2000, 28'h000_0080);
    wait_drain(sq_count);
    check_value("invalid_qp_drop_count_data", invalid_qp_drop_count_data, 1);

    // Outstanding limit with the ACK port stalled
    write_qp(4'd4, 1'b1, 6'h11, 1'b0);
    write_qp(4'd5, 1'b1, 6'h22, 1'b1);
    base     = sq_count;
    ack_hold = 1'b1;
    fork
      for (int i = 0; i < 6; i++) begin
        send_req((i % 2 == 0) ? OP_RDMA_WRITE : OP_RDMA_READ,
                 (i == 2) ? 4'd9 : qpn_t'(4 + (i % 2)), 1'b1, 1'b0,
                 vaddr_t'(48'h10_0000 + i * 256), len_t'(64 + i));
      end
    join_none
    repeat (40) @(posedge nclk);
    @(negedge nclk);
    check_value("sq transfers while ack_ready low", sq_count - base, RDMA_MAX_OUTSTANDING);
    check_value("ack_valid", ack_valid, 1'b1);
    @(posedge nclk);
    #2;
    ack_hold = 1'b0;
    wait_drain(base + 6);

    // Random traffic over random QP contents
    for (int q = 0; q < N_QP; q++) begin
      write_qp(qpn_t'(q), ($urandom_range(0, 3) != 0), pid_t'($urandom_range(0, 63)),
               vfid_t'($urandom_range(0, 1)));
    end
    base         = sq_count;
    ready_random = 1'b1;
    for (int n = 0; n < N_RANDOM; n++) begin
      send_random_req();
      repeat ($urandom_range(0, 2)) begin
        @(posedge nclk);
        #2;
      end
    end
    wait_drain(base + N_RANDOM);
    ready_random = 1'b0;

    if (exp_cmd_q.size() != 0) begin
      other_errors++;
      $display("%0d expected commands never came out", exp_cmd_q.size());
    end
    check_value("drop pulses", drops_seen, exp_drops);

    $display("Errors: %0d value mismatches, %0d other failures", value_errors, other_errors);
    if (value_errors == 0 && other_errors == 0) begin
      $display("Result: PASSED");
    end else begin
      $display("Result: FAILED");
    end
    $finish;
  end

endmodule

// File: verilog/ack_queue.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// ACK queue
// Small FIFO holding ACK words until the user takes them
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ps

module ack_queue (
  input  logic                nclk,
  input  logic                nresetn,

  input  logic                push,
  input  rdma_pkg::ack_word_t push_word,
  output logic                not_full,

  input  logic                pop,
  output logic                head_valid,
  output rdma_pkg::ack_word_t head_word
);

  import rdma_pkg::*;

  ack_word_t                     mem [ACK_QUEUE_DEPTH];
  logic [ACK_QUEUE_PTR_BITS-1:0] wr_ptr;
  logic [ACK_QUEUE_PTR_BITS-1:0] rd_ptr;
  logic [ACK_QUEUE_CNT_BITS-1:0] count_q;
  logic [ACK_QUEUE_CNT_BITS-1:0] count_n;
  logic                          do_push;
  logic                          do_pop;

  assign not_full  = (count_q < ACK_QUEUE_DEPTH);
  assign do_push   = push & not_full;
  assign do_pop    = pop & head_valid;
  assign head_word = mem[rd_ptr];

  always_comb begin
    case ({do_push, do_pop})
      2'b10:   count_n = count_q + 1'b1;
      2'b01:   count_n = count_q - 1'b1;
      default: count_n = count_q;
    endcase
  end

  // Depth is a power of two, pointers wrap by themselves
  always_ff @(posedge nclk) begin
    if (!nresetn) begin
      wr_ptr     <= '0;
      rd_ptr     <= '0;
      count_q    <= '0;
      head_valid <= 1'b0;
    end else begin
      count_q    <= count_n;
      head_valid <= (count_n != '0);
      if (do_push) begin
        wr_ptr <= wr_ptr + 1'b1;
      end
      if (do_pop) begin
        rd_ptr <= rd_ptr + 1'b1;
      end
    end
  end

  always_ff @(posedge nclk) begin
    if (do_push) begin
      mem[wr_ptr] <= push_word;
    end
  end

endmodule

// File: verilog/mem_pkg.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Memory command definitions
// Field widths and packed layout of read/write commands
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

package mem_pkg;

  localparam int VADDR_BITS = 48;
  typedef logic [VADDR_BITS-1:0] vaddr_t;

  // Transfer length in bytes
  localparam int LEN_BITS = 28;
  typedef logic [LEN_BITS-1:0] len_t;

  localparam int PID_BITS = 6;
  typedef logic [PID_BITS-1:0] pid_t;

  localparam int N_REGIONS_BITS = 1;
  typedef logic [N_REGIONS_BITS-1:0] vfid_t;

  // Command layout: vaddr, len, stream, host, pid, vfid
  localparam int CMD_LEN_OFFS    = VADDR_BITS;
  localparam int CMD_STREAM_OFFS = CMD_LEN_OFFS + LEN_BITS;
  localparam int CMD_HOST_OFFS   = CMD_STREAM_OFFS + 1;
  localparam int CMD_PID_OFFS    = CMD_HOST_OFFS + 1;
  localparam int CMD_VFID_OFFS   = CMD_PID_OFFS + PID_BITS;
  localparam int MEM_CMD_BITS    = CMD_VFID_OFFS + N_REGIONS_BITS;
  typedef logic [MEM_CMD_BITS-1:0] mem_cmd_word_t;

endpackage

// File: verilog/qp_context_table.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// QP context table
// Per-QP enable, owner pid and vfid with a registered lookup
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ps

module qp_context_table (
  input  logic           nclk,
  input  logic           nresetn,

  // Context write strobe
  input  logic           qp_wr,
  input  rdma_pkg::qpn_t qp_qpn,
  input  logic           qp_enable,
  input  mem_pkg::pid_t  qp_pid,
  input  mem_pkg::vfid_t qp_vfid,

  // Lookup, result one cycle later
  input  rdma_pkg::qpn_t lookup_qpn,
  output logic           ctx_enable,
  output mem_pkg::pid_t  ctx_pid,
  output mem_pkg::vfid_t ctx_vfid
);

  import rdma_pkg::*;
  import mem_pkg::*;

  logic  enable_mem [N_QP];
  pid_t  pid_mem    [N_QP];
  vfid_t vfid_mem   [N_QP];

  // Unwritten QPs read back disabled with zero owner
  always_ff @(posedge nclk) begin
    if (!nresetn) begin
      for (int i = 0; i < N_QP; i++) begin
        enable_mem[i] <= 1'b0;
        pid_mem[i]    <= '0;
        vfid_mem[i]   <= '0;
      end
    end else if (qp_wr) begin
      enable_mem[qp_qpn] <= qp_enable;
      pid_mem[qp_qpn]    <= qp_pid;
      vfid_mem[qp_qpn]   <= qp_vfid;
    end
  end

  // Read sees the entry before a same-cycle write
  always_ff @(posedge nclk) begin
    if (!nresetn) begin
      ctx_enable <= 1'b0;
      ctx_pid    <= '0;
      ctx_vfid   <= '0;
    end else begin
      ctx_enable <= enable_mem[lookup_qpn];
      ctx_pid    <= pid_mem[lookup_qpn];
      ctx_vfid   <= vfid_mem[lookup_qpn];
    end
  end

endmodule

// File: verilog/rdma_pkg.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// RDMA request definitions
// Opcodes, QP numbering, packed send-queue and ACK words,
// and flow-control limits of the command path
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

package rdma_pkg;

  // Opcode field, IB base transport encodings
  localparam int RDMA_OPCODE_BITS = 5;
  typedef logic [RDMA_OPCODE_BITS-1:0] rdma_opcode_t;

  localparam rdma_opcode_t OP_RDMA_WRITE = 5'h0a;
  localparam rdma_opcode_t OP_RDMA_READ  = 5'h0c;

  // Queue pair number, 16 QPs
  localparam int RDMA_QPN_BITS = 4;
  localparam int N_QP          = 1 << RDMA_QPN_BITS;
  typedef logic [RDMA_QPN_BITS-1:0] qpn_t;

  // Message holds vaddr in the low bits, len above it
  localparam int RDMA_MSG_BITS = mem_pkg::VADDR_BITS + mem_pkg::LEN_BITS;

  // Send-queue word layout, from bit 0 up
  localparam int RDMA_QPN_OFFS  = RDMA_OPCODE_BITS;
  localparam int RDMA_HOST_OFFS = RDMA_QPN_OFFS + RDMA_QPN_BITS;
  localparam int RDMA_MODE_OFFS = RDMA_HOST_OFFS + 1;
  localparam int RDMA_MSG_OFFS  = RDMA_MODE_OFFS + 1;
  localparam int RDMA_REQ_BITS  = RDMA_MSG_OFFS + RDMA_MSG_BITS;
  typedef logic [RDMA_REQ_BITS-1:0] sq_word_t;

  // ACK word layout: is_nak, pid, vfid
  localparam int ACK_PID_OFFS  = 1;
  localparam int ACK_VFID_OFFS = ACK_PID_OFFS + mem_pkg::PID_BITS;
  localparam int RDMA_ACK_BITS = ACK_VFID_OFFS + mem_pkg::N_REGIONS_BITS;
  typedef logic [RDMA_ACK_BITS-1:0] ack_word_t;

  // Flow control
  localparam int RDMA_MAX_OUTSTANDING = 4;
  localparam int OUTSTANDING_CNT_BITS = $clog2(RDMA_MAX_OUTSTANDING + 1);

  localparam int ACK_QUEUE_DEPTH    = 8;
  localparam int ACK_QUEUE_PTR_BITS = $clog2(ACK_QUEUE_DEPTH);
  localparam int ACK_QUEUE_CNT_BITS = $clog2(ACK_QUEUE_DEPTH + 1);

  typedef logic [31:0] drop_count_t;

endpackage

// File: verilog/req_dispatch.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Request dispatcher
// Turns send-queue words into memory commands and ACK
// entries, and counts requests to invalid QPs
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ps

module req_dispatch (
  input  logic                   nclk,
  input  logic                   nresetn,

  // Packed send queue
  input  logic                   sq_valid,
  output logic                   sq_ready,
  input  rdma_pkg::sq_word_t     sq_word,

  // Memory commands
  output logic                   rd_cmd_valid,
  input  logic                   rd_cmd_ready,
  output mem_pkg::mem_cmd_word_t rd_cmd_word,
  output logic                   wr_cmd_valid,
  input  logic                   wr_cmd_ready,
  output mem_pkg::mem_cmd_word_t wr_cmd_word,

  // QP context lookup
  output rdma_pkg::qpn_t         lookup_qpn,
  input  logic                   ctx_enable,
  input  mem_pkg::pid_t          ctx_pid,
  input  mem_pkg::vfid_t         ctx_vfid,

  // ACK queue push
  output logic                   ack_push,
  input  logic                   ack_not_full,
  output rdma_pkg::ack_word_t    ack_word,

  output logic                   drop_count_valid,
  output rdma_pkg::drop_count_t  drop_count_data
);

  import rdma_pkg::*;
  import mem_pkg::*;

  typedef enum logic [1:0] {
    IDLE,
    LOOKUP,
    ISSUE,
    ACK
  } state_t;

  state_t        state_q;
  state_t        state_n;
  sq_word_t      req_q;
  mem_cmd_word_t cmd_q;
  rdma_opcode_t  req_opcode;
  logic          is_write;
  logic          is_read;
  logic          req_ok;
  logic          sq_fire;
  logic          cmd_fire;

  assign req_opcode = req_q[0 +: RDMA_OPCODE_BITS];
  assign is_write   = (req_opcode == OP_RDMA_WRITE);
  assign is_read    = (req_opcode == OP_RDMA_READ);
  // Only valid while in LOOKUP, when the context is back
  assign req_ok     = ctx_enable & (is_write | is_read);

  // Table registers this on the accept edge
  assign lookup_qpn = sq_word[RDMA_QPN_OFFS +: RDMA_QPN_BITS];

  assign sq_fire  = sq_valid & sq_ready;
  assign cmd_fire = (rd_cmd_valid & rd_cmd_ready) | (wr_cmd_valid & wr_cmd_ready);

  // One command register, the valids select the port
  assign rd_cmd_word = cmd_q;
  assign wr_cmd_word = cmd_q;

  assign ack_push = (state_q == ACK) & ack_not_full;

  always_comb begin
    state_n = state_q;
    case (state_q)
      IDLE: begin
        if (sq_fire) begin
          state_n = LOOKUP;
        end
      end
      LOOKUP: begin
        state_n = req_ok ? ISSUE : ACK;
      end
      ISSUE: begin
        if (cmd_fire) begin
          state_n = ACK;
        end
      end
      ACK: begin
        // Wait here while the ACK queue is full
        if (ack_not_full) begin
          state_n = IDLE;
        end
      end
      default: begin
        state_n = IDLE;
      end
    endcase
  end

  always_ff @(posedge nclk) begin
    if (!nresetn) begin
      state_q          <= IDLE;
      sq_ready         <= 1'b0;
      rd_cmd_valid     <= 1'b0;
      wr_cmd_valid     <= 1'b0;
      drop_count_valid <= 1'b0;
      drop_count_data  <= '0;
    end else begin
      state_q          <= state_n;
      sq_ready         <= (state_n == IDLE);
      drop_count_valid <= 1'b0;
      if (state_q == LOOKUP) begin
        // WRITE fetches local data, READ lands returned data
        rd_cmd_valid <= ctx_enable & is_write;
        wr_cmd_valid <= ctx_enable & is_read;
        if (!ctx_enable) begin
          drop_count_valid <= 1'b1;
          drop_count_data  <= drop_count_data + 1'b1;
        end
      end else if (cmd_fire) begin
        rd_cmd_valid <= 1'b0;
        wr_cmd_valid <= 1'b0;
      end
    end
  end

  // Request, command and ACK payload
  always_ff @(posedge nclk) begin
    if (sq_fire) begin
      req_q <= sq_word;
    end
    if (state_q == LOOKUP) begin
      cmd_q[0 +: VADDR_BITS]           <= req_q[RDMA_MSG_OFFS +: VADDR_BITS];
      cmd_q[CMD_LEN_OFFS +: LEN_BITS]  <= req_q[RDMA_MSG_OFFS + VADDR_BITS +: LEN_BITS];
      cmd_q[CMD_STREAM_OFFS]           <= req_q[RDMA_MODE_OFFS];
      cmd_q[CMD_HOST_OFFS]             <= req_q[RDMA_HOST_OFFS];
      cmd_q[CMD_PID_OFFS +: PID_BITS]  <= ctx_pid;
      cmd_q[CMD_VFID_OFFS +: N_REGIONS_BITS] <= ctx_vfid;

      ack_word[0]                              <= ~req_ok;
      ack_word[ACK_PID_OFFS +: PID_BITS]       <= ctx_pid;
      ack_word[ACK_VFID_OFFS +: N_REGIONS_BITS] <= ctx_vfid;
    end
  end

endmodule

// File: verilog/roce_stack.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// RoCE command path
// Send queue in, memory read/write commands and ACKs out,
// with a limit on unacknowledged requests
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ps

module roce_stack (
  input  logic                  nclk,
  input  logic                  nresetn,

  // Send queue
  input  logic                  sq_valid,
  output logic                  sq_ready,
  input  rdma_pkg::rdma_opcode_t sq_opcode,
  input  rdma_pkg::qpn_t        sq_qpn,
  input  logic                  sq_host,
  input  logic                  sq_mode,
  input  mem_pkg::vaddr_t       sq_vaddr,
  input  mem_pkg::len_t         sq_len,

  // Memory read command
  output logic                  rd_req_valid,
  input  logic                  rd_req_ready,
  output mem_pkg::vaddr_t       rd_req_vaddr,
  output mem_pkg::len_t         rd_req_len,
  output logic                  rd_req_stream,
  output logic                  rd_req_host,
  output mem_pkg::pid_t         rd_req_pid,
  output mem_pkg::vfid_t        rd_req_vfid,

  // Memory write command
  output logic                  wr_req_valid,
  input  logic                  wr_req_ready,
  output mem_pkg::vaddr_t       wr_req_vaddr,
  output mem_pkg::len_t         wr_req_len,
  output logic                  wr_req_stream,
  output logic                  wr_req_host,
  output mem_pkg::pid_t         wr_req_pid,
  output mem_pkg::vfid_t        wr_req_vfid,

  // ACK to the user
  output logic                  ack_valid,
  input  logic                  ack_ready,
  output logic                  ack_is_nak,
  output mem_pkg::pid_t         ack_pid,
  output mem_pkg::vfid_t        ack_vfid,

  // QP context write
  input  logic                  qp_wr,
  input  rdma_pkg::qpn_t        qp_qpn,
  input  logic                  qp_enable,
  input  mem_pkg::pid_t         qp_pid,
  input  mem_pkg::vfid_t        qp_vfid,

  output logic                  invalid_qp_drop_count_valid,
  output rdma_pkg::drop_count_t invalid_qp_drop_count_data
);

  import rdma_pkg::*;
  import mem_pkg::*;

  sq_word_t      sq_word;
  logic          disp_sq_valid;
  logic          disp_sq_ready;
  mem_cmd_word_t rd_cmd_word;
  mem_cmd_word_t wr_cmd_word;
  qpn_t          lookup_qpn;
  logic          ctx_enable;
  pid_t          ctx_pid;
  vfid_t         ctx_vfid;
  logic          ack_push;
  logic          ack_not_full;
  ack_word_t     ack_push_word;
  ack_word_t     ack_head_word;

  logic [OUTSTANDING_CNT_BITS-1:0] cnt_q;
  logic [OUTSTANDING_CNT_BITS-1:0] cnt_n;
  logic                            sq_room;

  // Pack send-queue fields
  always_comb begin
    sq_word[0 +: RDMA_OPCODE_BITS]                  = sq_opcode;
    sq_word[RDMA_QPN_OFFS +: RDMA_QPN_BITS]         = sq_qpn;
    sq_word[RDMA_HOST_OFFS]                         = sq_host;
    sq_word[RDMA_MODE_OFFS]                         = sq_mode;
    sq_word[RDMA_MSG_OFFS +: VADDR_BITS]            = sq_vaddr;
    sq_word[RDMA_MSG_OFFS + VADDR_BITS +: LEN_BITS] = sq_len;
  end

  // Unpack commands
  assign rd_req_vaddr  = rd_cmd_word[0 +: VADDR_BITS];
  assign rd_req_len    = rd_cmd_word[CMD_LEN_OFFS +: LEN_BITS];
  assign rd_req_stream = rd_cmd_word[CMD_STREAM_OFFS];
  assign rd_req_host   = rd_cmd_word[CMD_HOST_OFFS];
  assign rd_req_pid    = rd_cmd_word[CMD_PID_OFFS +: PID_BITS];
  assign rd_req_vfid   = rd_cmd_word[CMD_VFID_OFFS +: N_REGIONS_BITS];

  assign wr_req_vaddr  = wr_cmd_word[0 +: VADDR_BITS];
  assign wr_req_len    = wr_cmd_word[CMD_LEN_OFFS +: LEN_BITS];
  assign wr_req_stream = wr_cmd_word[CMD_STREAM_OFFS];
  assign wr_req_host   = wr_cmd_word[CMD_HOST_OFFS];
  assign wr_req_pid    = wr_cmd_word[CMD_PID_OFFS +: PID_BITS];
  assign wr_req_vfid   = wr_cmd_word[CMD_VFID_OFFS +: N_REGIONS_BITS];

  // Unpack ACK head
  assign ack_is_nak = ack_head_word[0];
  assign ack_pid    = ack_head_word[ACK_PID_OFFS +: PID_BITS];
  assign ack_vfid   = ack_head_word[ACK_VFID_OFFS +: N_REGIONS_BITS];

  // Outstanding requests, up on accept and down on ACK taken
  always_comb begin
    cnt_n = cnt_q;
    if (ack_valid & ack_ready) begin
      cnt_n = cnt_n - 1'b1;
    end
    if (sq_valid & sq_ready) begin
      cnt_n = cnt_n + 1'b1;
    end
  end

  always_ff @(posedge nclk) begin
    if (!nresetn) begin
      cnt_q <= '0;
    end else begin
      cnt_q <= cnt_n;
    end
  end

  assign sq_room       = (cnt_q < RDMA_MAX_OUTSTANDING);
  assign sq_ready      = disp_sq_ready & sq_room;
  assign disp_sq_valid = sq_valid & sq_room;

  qp_context_table u_qp_table (
    .nclk       (nclk),
    .nresetn    (nresetn),
    .qp_wr      (qp_wr),
    .qp_qpn     (qp_qpn),
    .qp_enable  (qp_enable),
    .qp_pid     (qp_pid),
    .qp_vfid    (qp_vfid),
    .lookup_qpn (lookup_qpn),
    .ctx_enable (ctx_enable),
    .ctx_pid    (ctx_pid),
    .ctx_vfid   (ctx_vfid)
  );

  req_dispatch u_dispatch (
    .nclk             (nclk),
    .nresetn          (nresetn),
    .sq_valid         (disp_sq_valid),
    .sq_ready         (disp_sq_ready),
    .sq_word          (sq_word),
    .rd_cmd_valid     (rd_req_valid),
    .rd_cmd_ready     (rd_req_ready),
    .rd_cmd_word      (rd_cmd_word),
    .wr_cmd_valid     (wr_req_valid),
    .wr_cmd_ready     (wr_req_ready),
    .wr_cmd_word      (wr_cmd_word),
    .lookup_qpn       (lookup_qpn),
    .ctx_enable       (ctx_enable),
    .ctx_pid          (ctx_pid),
    .ctx_vfid         (ctx_vfid),
    .ack_push         (ack_push),
    .ack_not_full     (ack_not_full),
    .ack_word         (ack_push_word),
    .drop_count_valid (invalid_qp_drop_count_valid),
    .drop_count_data  (invalid_qp_drop_count_data)
  );

  ack_queue u_ack_queue (
    .nclk       (nclk),
    .nresetn    (nresetn),
    .push       (ack_push),
    .push_word  (ack_push_word),
    .not_full   (ack_not_full),
    .pop        (ack_valid & ack_ready),
    .head_valid (ack_valid),
    .head_word  (ack_head_word)
  );

endmodule
